/* rtl/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // function codes of the R-type group, inst[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam word_t RESET_PC = 32'h0000_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage payloads, an all-zero value is a bubble
    typedef struct packed {
        word_t inst;
        word_t pc;
    } ifid_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      we;
        reg_addr_t dst;
        word_t     s_val;
        word_t     t_val;
        word_t     imm;
    } idex_t;

    typedef struct packed {
        logic      we;
        logic      is_load;
        logic      is_store;
        reg_addr_t dst;
        word_t     alu_res;
        word_t     store_data;
    } exmm_t;

    typedef struct packed {
        logic      we;
        reg_addr_t dst;
        word_t     value;
    } memwb_t;

endpackage

/* rtl/fwd_if.sv */
`timescale 1ns/100ps

// one stage's register write that has not reached the register file yet
interface fwd_if;

    logic        we;      // stage will write dst
    logic        is_load; // value is not known until the memory stage
    logic [4:0]  dst;
    logic [31:0] value;

    modport src (
        output we, is_load, dst, value
    );

    modport sink (
        input we, is_load, dst, value
    );

endinterface

/* rtl/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg
    import mips_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all flags of a payload are zero in a bubble, so it writes nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (bubble_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps

module regfile
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr_s_i,
    input  reg_addr_t raddr_t_i,
    output word_t     rdata_s_o,
    output word_t     rdata_t_o
);

    word_t regs [32];

    logic wr_valid;

    assign wr_valid = we_i && (waddr_i != '0); // r0 is never written, so it stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback and decode share a cycle, the new value wins
    assign rdata_s_o = (wr_valid && waddr_i == raddr_s_i) ? wdata_i : regs[raddr_s_i];
    assign rdata_t_o = (wr_valid && waddr_i == raddr_t_i) ? wdata_i : regs[raddr_t_i];

endmodule

/* rtl/decoder.sv */
`timescale 1ns/100ps

module decoder
    import mips_pkg::*;
(
    input  word_t     inst_i,
    output alu_op_t   alu_op_o,
    output logic      use_imm_o,
    output logic      is_load_o,
    output logic      is_store_o,
    output logic      we_o,
    output reg_addr_t rs_o,
    output reg_addr_t rt_o,
    output reg_addr_t rd_o,
    output word_t     imm_o,
    output logic      is_beq_o,
    output logic      is_bne_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        zero_ext;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];

    // logical immediates take the upper half as zero
    assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI);
    assign imm_o    = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    assign is_beq_o = (opcode == OP_BEQ);
    assign is_bne_o = (opcode == OP_BNE);

    always_comb begin
        alu_op_o   = ALU_ADD;
        use_imm_o  = 1'b0;
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        we_o       = 1'b0;
        rd_o       = inst_i[20:16]; // immediate forms write rt

        case (opcode)
            OP_RTYPE: begin
                rd_o = inst_i[15:11];
                we_o = 1'b1;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    FN_SLTU: alu_op_o = ALU_SLTU;
                    default: we_o = 1'b0; // includes the all-zero NOP
                endcase
            end
            OP_ADDIU: begin
                use_imm_o = 1'b1;
                we_o      = 1'b1;
            end
            OP_ANDI: begin
                alu_op_o  = ALU_AND;
                use_imm_o = 1'b1;
                we_o      = 1'b1;
            end
            OP_ORI: begin
                alu_op_o  = ALU_OR;
                use_imm_o = 1'b1;
                we_o      = 1'b1;
            end
            OP_LUI: begin
                alu_op_o  = ALU_LUI;
                use_imm_o = 1'b1;
                we_o      = 1'b1;
            end
            OP_LW: begin
                use_imm_o = 1'b1;
                is_load_o = 1'b1;
                we_o      = 1'b1;
            end
            OP_SW: begin
                use_imm_o  = 1'b1;
                is_store_o = 1'b1;
            end
            default: ; // branches and unknown codes write nothing
        endcase
    end

endmodule

/* rtl/operand_fwd.sv */
`timescale 1ns/100ps

module operand_fwd
    import mips_pkg::*;
(
    input  reg_addr_t   reg_i,
    input  word_t       regfile_i,
    fwd_if.sink         ex,
    fwd_if.sink         mm,
    output word_t       value_o
);

    logic ex_hit;
    logic mm_hit;

    // a load still in execute has no data yet and is skipped
    assign ex_hit = ex.we && !ex.is_load && (ex.dst == reg_i);
    assign mm_hit = mm.we && !mm.is_load && (mm.dst == reg_i);

    always_comb begin
        if (reg_i == '0) value_o = '0;
        else if (ex_hit) value_o = ex.value; // newest writer first
        else if (mm_hit) value_o = mm.value;
        else value_o = regfile_i;
    end

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit
    import mips_pkg::*;
(
    input  word_t pc_i,
    input  word_t imm_i,
    input  logic  is_beq_i,
    input  logic  is_bne_i,
    input  word_t s_val_i,
    input  word_t t_val_i,
    output logic  taken_o,
    output word_t target_o
);

    logic  equal;
    word_t slot_pc;
    word_t offset;

    assign equal = (s_val_i == t_val_i);

    assign taken_o = (is_beq_i && equal) || (is_bne_i && !equal);

    // offsets count words from the delay slot
    assign slot_pc  = pc_i + 32'd4;
    assign offset   = {imm_i[29:0], 2'b00};
    assign target_o = slot_pc + offset;

endmodule

/* rtl/alu_stage.sv */
`timescale 1ns/100ps

module alu_stage
    import mips_pkg::*;
(
    input  idex_t  idex_i,
    output exmm_t  exmm_o,
    fwd_if.src     fwd
);

    word_t op_a;
    word_t op_b;
    word_t result;

    assign op_a = idex_i.s_val;
    assign op_b = idex_i.use_imm ? idex_i.imm : idex_i.t_val;

    always_comb begin
        case (idex_i.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // loads and stores use result as the address
    always_comb begin
        exmm_o.we         = idex_i.we;
        exmm_o.is_load    = idex_i.is_load;
        exmm_o.is_store   = idex_i.is_store;
        exmm_o.dst        = idex_i.dst;
        exmm_o.alu_res    = result;
        exmm_o.store_data = idex_i.t_val;
    end

    assign fwd.we      = idex_i.we;
    assign fwd.is_load = idex_i.is_load; // load data arrives one stage later
    assign fwd.dst     = idex_i.dst;
    assign fwd.value   = result;

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage
    import mips_pkg::*;
(
    input  exmm_t  exmm_i,
    fwd_if.src     fwd,
    output word_t  dmem_addr_o,
    output word_t  dmem_wdata_o,
    output logic   dmem_rd_o,
    output logic   dmem_wr_o,
    input  word_t  dmem_rdata_i,
    output memwb_t memwb_o
);

    word_t result;

    assign dmem_addr_o  = exmm_i.alu_res;
    assign dmem_wdata_o = exmm_i.store_data;
    assign dmem_rd_o    = exmm_i.is_load;
    assign dmem_wr_o    = exmm_i.is_store;

    // data memory answers in the same cycle
    assign result = exmm_i.is_load ? dmem_rdata_i : exmm_i.alu_res;

    assign memwb_o.we    = exmm_i.we;
    assign memwb_o.dst   = exmm_i.dst;
    assign memwb_o.value = result;

    // the load data is already on the bus here, so the value is final
    assign fwd.we      = exmm_i.we;
    assign fwd.is_load = 1'b0;
    assign fwd.dst     = exmm_i.dst;
    assign fwd.value   = result;

endmodule

/* rtl/mips_core.sv */
`timescale 1ns/100ps

module mips_core
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output word_t imem_addr_o,
    input  word_t imem_data_i,
    output word_t dmem_addr_o,
    output word_t dmem_wdata_o,
    output logic  dmem_rd_o,
    output logic  dmem_wr_o,
    input  word_t dmem_rdata_i
);

    word_t pc_q;

    ifid_t  ifid_d, ifid_q;
    idex_t  idex_d, idex_q;
    exmm_t  exmm_d, exmm_q;
    memwb_t memwb_d, memwb_q;

    alu_op_t   dec_alu_op;
    logic      dec_use_imm, dec_is_load, dec_is_store, dec_we;
    logic      dec_is_beq, dec_is_bne;
    reg_addr_t dec_rs, dec_rt, dec_rd;
    word_t     dec_imm;
    word_t     rf_s, rf_t;
    word_t     s_val, t_val;
    logic      br_taken;
    word_t     br_target;

    fwd_if fwd_ex ();
    fwd_if fwd_mm ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch

    // a taken branch lands after its delay slot has been fetched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= br_taken ? br_target : pc_q + 32'd4;
        end
    end

    assign imem_addr_o = pc_q;
    assign ifid_d      = '{inst: imem_data_i, pc: pc_q};

    pipe_reg #(.payload_t(ifid_t)) ifid (
        .clk(clk), .rst_n(rst_n), .bubble_i(!rst_n), .d_i(ifid_d), .q_o(ifid_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode, operands and branch resolve here

    decoder dec0 (
        .inst_i(ifid_q.inst), .alu_op_o(dec_alu_op), .use_imm_o(dec_use_imm),
        .is_load_o(dec_is_load), .is_store_o(dec_is_store), .we_o(dec_we),
        .rs_o(dec_rs), .rt_o(dec_rt), .rd_o(dec_rd), .imm_o(dec_imm),
        .is_beq_o(dec_is_beq), .is_bne_o(dec_is_bne)
    );

    regfile rf0 (
        .clk(clk), .rst_n(rst_n), .we_i(memwb_q.we), .waddr_i(memwb_q.dst),
        .wdata_i(memwb_q.value), .raddr_s_i(dec_rs), .raddr_t_i(dec_rt),
        .rdata_s_o(rf_s), .rdata_t_o(rf_t)
    );

    operand_fwd fwd_s (
        .reg_i(dec_rs), .regfile_i(rf_s), .ex(fwd_ex), .mm(fwd_mm), .value_o(s_val)
    );

    operand_fwd fwd_t (
        .reg_i(dec_rt), .regfile_i(rf_t), .ex(fwd_ex), .mm(fwd_mm), .value_o(t_val)
    );

    branch_unit br0 (
        .pc_i(ifid_q.pc), .imm_i(dec_imm), .is_beq_i(dec_is_beq), .is_bne_i(dec_is_bne),
        .s_val_i(s_val), .t_val_i(t_val), .taken_o(br_taken), .target_o(br_target)
    );

    always_comb begin
        idex_d.alu_op   = dec_alu_op;
        idex_d.use_imm  = dec_use_imm;
        idex_d.is_load  = dec_is_load;
        idex_d.is_store = dec_is_store;
        idex_d.we       = dec_we;
        idex_d.dst      = dec_rd;
        idex_d.s_val    = s_val;
        idex_d.t_val    = t_val;
        idex_d.imm      = dec_imm;
    end

    pipe_reg #(.payload_t(idex_t)) idex (
        .clk(clk), .rst_n(rst_n), .bubble_i(1'b0), .d_i(idex_d), .q_o(idex_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute and memory

    alu_stage ex0 (.idex_i(idex_q), .exmm_o(exmm_d), .fwd(fwd_ex));

    pipe_reg #(.payload_t(exmm_t)) exmm (
        .clk(clk), .rst_n(rst_n), .bubble_i(1'b0), .d_i(exmm_d), .q_o(exmm_q)
    );

    mem_stage mm0 (
        .exmm_i(exmm_q), .fwd(fwd_mm), .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o), .dmem_rd_o(dmem_rd_o), .dmem_wr_o(dmem_wr_o),
        .dmem_rdata_i(dmem_rdata_i), .memwb_o(memwb_d)
    );

    // writeback is the regfile port above
    pipe_reg #(.payload_t(memwb_t)) memwb (
        .clk(clk), .rst_n(rst_n), .bubble_i(1'b0), .d_i(memwb_d), .q_o(memwb_q)
    );

endmodule

/* test/tb_mips_core.sv */
`timescale 1ns/100ps

module tb_mips_core
    import mips_pkg::*;
();

    localparam int    N_RAND    = 150;           // random instructions before the register dump
    localparam word_t DATA_BASE = 32'h0000_0400;
    localparam int    TIMEOUT   = 2000;

    logic  clk;
    logic  rst_n;
    word_t imem_addr, imem_data;
    word_t dmem_addr, dmem_wdata, dmem_rdata;
    logic  dmem_rd, dmem_wr;

    word_t imem [256];
    word_t dmem [64];
    word_t ref_mem [64];
    word_t ref_regs [32];

    // every fetched instruction executes, so one trace entry stands for one cycle
    word_t tr_pc [$];
    int    tr_kind [$]; // 0 no access, 1 load, 2 store
    word_t tr_addr [$];
    word_t tr_data [$];

    word_t halt_pc;
    int    cycle;
    logic  halt_seen;
    int    fetch_errors, bus_errors, store_errors;

    mips_core dut0 (
        .clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_rd_o(dmem_rd),
        .dmem_wr_o(dmem_wr), .dmem_rdata_i(dmem_rdata)
    );

    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generation

    function automatic word_t encode_rtype(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                           reg_addr_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'b0, funct};
    endfunction

    function automatic word_t encode_itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [15:0] data_offset();
        return DATA_BASE[15:0] + {8'h00, 6'($urandom_range(0, 63)), 2'b00};
    endfunction

    function automatic reg_addr_t pick_src(reg_addr_t avoid);
        reg_addr_t r;
        r = reg_addr_t'($urandom_range(0, 31));
        while (avoid != '0 && r == avoid) begin // the load result is not there yet
            r = reg_addr_t'($urandom_range(0, 31));
        end
        return r;
    endfunction

    function automatic word_t random_op(reg_addr_t avoid, logic allow_load,
                                        output reg_addr_t load_dst);
        int          kind;
        reg_addr_t   rd, rs, rt;
        logic [15:0] imm;
        word_t       inst;
        kind     = allow_load ? $urandom_range(0, 12) : $urandom_range(0, 11);
        rd       = reg_addr_t'($urandom_range(0, 31));
        rs       = pick_src(avoid);
        rt       = pick_src(avoid);
        imm      = 16'($urandom);
        load_dst = '0;
        case (kind)
            0: inst = encode_rtype(FN_ADDU, rs, rt, rd);
            1: inst = encode_rtype(FN_SUBU, rs, rt, rd);
            2: inst = encode_rtype(FN_AND, rs, rt, rd);
            3: inst = encode_rtype(FN_OR, rs, rt, rd);
            4: inst = encode_rtype(FN_XOR, rs, rt, rd);
            5: inst = encode_rtype(FN_SLT, rs, rt, rd);
            6: inst = encode_rtype(FN_SLTU, rs, rt, rd);
            7: inst = encode_itype(OP_ADDIU, rs, rd, imm);
            8: inst = encode_itype(OP_ANDI, rs, rd, imm);
            9: inst = encode_itype(OP_ORI, rs, rd, imm);
            10: inst = encode_itype(OP_LUI, 5'd0, rd, imm);
            11: inst = encode_itype(OP_SW, 5'd0, rt, data_offset());
            default: begin
                inst     = encode_itype(OP_LW, 5'd0, rd, data_offset());
                load_dst = rd;
            end
        endcase
        return inst;
    endfunction

    task automatic build_program();
        int          i, t;
        reg_addr_t   avoid, ld, rs, rt;
        logic [5:0]  op;
        for (i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        i     = 0;
        avoid = '0;
        while (i < N_RAND) begin
            if (i < N_RAND - 2 && $urandom_range(0, 7) == 0) begin
                rs = pick_src(avoid);
                rt = ($urandom_range(0, 1) == 0) ? rs : pick_src(avoid);
                op = ($urandom_range(0, 1) == 0) ? OP_BEQ : OP_BNE;
                t  = i + 2 + $urandom_range(0, 6); // forward and past the delay slot
                if (t > N_RAND) begin
                    t = N_RAND;
                end
                imem[i]     = encode_itype(op, rs, rt, 16'(t - i - 1));
                imem[i + 1] = random_op('0, 1'b0, ld); // no load in a delay slot
                avoid       = '0;
                i += 2;
            end else begin
                imem[i] = random_op(avoid, i < N_RAND - 1, ld);
                avoid   = ld;
                i += 1;
            end
        end
        for (i = 1; i < 32; i++) begin
            imem[N_RAND + i - 1] = encode_itype(OP_SW, 5'd0, 5'(i), DATA_BASE[15:0] + 16'(4 * i));
        end
        halt_pc = word_t'((N_RAND + 31) * 4);
        imem[N_RAND + 31] = encode_itype(OP_BEQ, 5'd0, 5'd0, 16'hffff); // NOP slot follows
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ISA reference model with a branch delay slot

    task automatic run_model();
        word_t     pc, npc, nnpc, inst, a, b, imm_s, imm_z, wr_val, addr, data;
        reg_addr_t rs, rt, rd, wr_reg;
        int        kind, idx, stop;
        for (idx = 0; idx < 64; idx++) begin
            ref_mem[idx] = fill_word(DATA_BASE + word_t'(idx * 4));
        end
        for (idx = 0; idx < 32; idx++) begin
            ref_regs[idx] = '0;
        end
        pc   = RESET_PC;
        npc  = RESET_PC + 32'd4;
        stop = TIMEOUT;
        while (tr_pc.size() < stop) begin
            if (pc == halt_pc && stop == TIMEOUT) begin
                stop = tr_pc.size() + 5; // a few loops of the halt let the dump drain
            end
            inst   = imem[pc[9:2]];
            rs     = inst[25:21];
            rt     = inst[20:16];
            rd     = inst[15:11];
            a      = ref_regs[rs];
            b      = ref_regs[rt];
            imm_s  = {{16{inst[15]}}, inst[15:0]};
            imm_z  = {16'h0000, inst[15:0]};
            nnpc   = npc + 32'd4;
            wr_reg = '0;
            wr_val = '0;
            kind   = 0;
            addr   = '0;
            data   = '0;
            case (inst[31:26])
                OP_RTYPE: begin
                    wr_reg = rd;
                    case (inst[5:0])
                        FN_ADDU: wr_val = a + b;
                        FN_SUBU: wr_val = a - b;
                        FN_AND:  wr_val = a & b;
                        FN_OR:   wr_val = a | b;
                        FN_XOR:  wr_val = a ^ b;
                        FN_SLT:  wr_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLTU: wr_val = (a < b) ? 32'd1 : 32'd0;
                        default: wr_reg = '0;
                    endcase
                end
                OP_ADDIU: begin
                    wr_reg = rt;
                    wr_val = a + imm_s;
                end
                OP_ANDI: begin
                    wr_reg = rt;
                    wr_val = a & imm_z;
                end
                OP_ORI: begin
                    wr_reg = rt;
                    wr_val = a | imm_z;
                end
                OP_LUI: begin
                    wr_reg = rt;
                    wr_val = {inst[15:0], 16'h0000};
                end
                OP_LW: begin
                    addr   = a + imm_s;
                    wr_reg = rt;
                    wr_val = ref_mem[addr[7:2]];
                    kind   = 1;
                end
                OP_SW: begin
                    addr = a + imm_s;
                    data = b;
                    ref_mem[addr[7:2]] = b;
                    kind = 2;
                end
                OP_BEQ: if (a == b) nnpc = pc + 32'd4 + (imm_s << 2);
                OP_BNE: if (a != b) nnpc = pc + 32'd4 + (imm_s << 2);
                default: ;
            endcase
            if (wr_reg != '0) begin
                ref_regs[wr_reg] = wr_val;
            end
            tr_pc.push_back(pc);
            tr_kind.push_back(kind);
            tr_addr.push_back(addr);
            tr_data.push_back(data);
            pc  = npc;
            npc = nnpc;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks

    task automatic check_fetch(input word_t exp_pc);
        if (imem_addr !== exp_pc) begin
            fetch_errors++;
            $display("** Error at %0t: fetch address %h, expected %h", $time, imem_addr, exp_pc);
        end
    endtask

    task automatic check_access(input logic exp_rd, input logic exp_wr);
        if (dmem_rd !== exp_rd || dmem_wr !== exp_wr) begin
            bus_errors++;
            $display("** Error at %0t: dmem rd/wr %b/%b, expected %b/%b", $time,
                     dmem_rd, dmem_wr, exp_rd, exp_wr);
        end
    endtask

    task automatic check_load(input word_t exp_addr);
        if (dmem_addr !== exp_addr) begin
            bus_errors++;
            $display("** Error at %0t: load from %h, expected %h", $time, dmem_addr, exp_addr);
        end
    endtask

    task automatic check_store(input word_t exp_addr, input word_t exp_data);
        if (dmem_addr !== exp_addr || dmem_wdata !== exp_data) begin
            store_errors++;
            $display("** Error at %0t: store %h to %h, expected %h to %h", $time,
                     dmem_wdata, dmem_addr, exp_data, exp_addr);
        end
    endtask

    // memories answer 2 ns after the edge from the addresses the DUT presents
    always @(posedge clk) begin
        #2;
        imem_data  = imem[imem_addr[9:2]];
        dmem_rdata = dmem[dmem_addr[7:2]];
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            check_access(1'b0, 1'b0);
        end else if (cycle < tr_pc.size()) begin
            check_fetch(tr_pc[cycle]);
            if (imem_addr == halt_pc) halt_seen = 1'b1;
            if (cycle >= 3) begin // memory stage is three cycles behind fetch
                check_access(tr_kind[cycle - 3] == 1, tr_kind[cycle - 3] == 2);
                if (tr_kind[cycle - 3] == 1) begin
                    check_load(tr_addr[cycle - 3]);
                end else if (tr_kind[cycle - 3] == 2) begin
                    check_store(tr_addr[cycle - 3], tr_data[cycle - 3]);
                end
            end else begin
                check_access(1'b0, 1'b0);
            end
            if (dmem_wr) dmem[dmem_addr[7:2]] = dmem_wdata;
            cycle++;
        end
    end

    initial begin
        int waited;
        void'($urandom(32'h3d89f1f4));
        clk          = 1'b0;
        rst_n        = 1'b0;
        imem_data    = '0;
        dmem_rdata   = '0;
        cycle        = 0;
        halt_seen    = 1'b0;
        fetch_errors = 0;
        bus_errors   = 0;
        store_errors = 0;
        build_program();
        for (waited = 0; waited < 64; waited++) begin
            dmem[waited] = fill_word(DATA_BASE + word_t'(waited * 4));
        end
        run_model();

        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;

        waited = 0;
        while (!halt_seen && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!halt_seen) begin
            $display("timed out waiting for the fetch at the halt address %h", halt_pc);
        end else begin
            waited = 0;
            while (cycle < tr_pc.size() && waited < 16) begin
                @(posedge clk);
                waited++;
            end
            if (cycle < tr_pc.size()) begin
                $display("timed out while the register dump drained through the pipeline");
            end
        end

        $display("fetch errors %0d, bus errors %0d, store errors %0d",
                 fetch_errors, bus_errors, store_errors);
        if (halt_seen && cycle >= tr_pc.size()
                && fetch_errors + bus_errors + store_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/mips_pkg.sv
rtl/fwd_if.sv
rtl/pipe_reg.sv
rtl/regfile.sv
rtl/decoder.sv
rtl/operand_fwd.sv
rtl/branch_unit.sv
rtl/alu_stage.sv
rtl/mem_stage.sv
rtl/mips_core.sv
test/tb_mips_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module tb_mips_core -f list.f
./obj_dir/Vtb_mips_core | tee sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
